// ==== Makefile ====
# Verilator simulation of the packed arithmetic coprocessor

VERILATOR ?= verilator
TOP       ?= scarv_cop_tb
FILELIST  ?= scarv_cop.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

# Build, run, then decide on the log contents
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/scarv_cop_config.svh ====
/*
 * Coprocessor configuration macros
 * Major opcode, function codes, buffer depth and register count
 */
`ifndef SCARV_COP_CONFIG_SVH
`define SCARV_COP_CONFIG_SVH

`define SCARV_COP_OPCODE        7'b0001011  // custom-0 major opcode

`define SCARV_COP_F_PADD        4'd0
`define SCARV_COP_F_PSUB        4'd1
`define SCARV_COP_F_GPR2XCR     4'd2
`define SCARV_COP_F_XCR2GPR     4'd3

`define SCARV_COP_FIFO_DEPTH    4           // Power of two
`define SCARV_COP_NXCR          16

`endif

// ==== common/scarv_cop_pkg.sv ====
/*
 * Coprocessor shared types
 * Instruction word views, decoded operation, host request and response
 */
package scarv_cop_pkg;

    // Packed arithmetic view of the instruction word
    typedef struct packed {
        logic [3:0] funct;
        logic [2:0] pw;
        logic [3:0] crs2;
        logic [1:0] rsvd_20_19;
        logic [3:0] crs1;
        logic [3:0] rsvd_14_11;
        logic [3:0] crd;
        logic [6:0] opcode;
    } cop_insn_pk_t;

    // Move view, GPR index rd spans rd_hi and crd
    typedef struct packed {
        logic [3:0] funct;
        logic [2:0] rsvd_27_25;
        logic [3:0] crs;
        logic       rsvd_20;
        logic [4:0] rs1;
        logic [2:0] rsvd_14_12;
        logic       rd_hi;
        logic [3:0] crd;
        logic [6:0] opcode;
    } cop_insn_mv_t;

    typedef union packed {
        cop_insn_pk_t pk;
        cop_insn_mv_t mv;
    } cop_insn_u;

    typedef enum logic [1:0] {
        PACKED   = 2'd0,
        MOVE_IN  = 2'd1,  // GPR2XCR
        MOVE_OUT = 2'd2   // XCR2GPR
    } cop_class_e;

    typedef struct packed {
        cop_insn_u   insn;
        logic [31:0] rs1_data;
    } cop_req_t;

    typedef struct packed {
        cop_class_e  cls;
        logic        sub;       // Subtract for packed ops
        logic [2:0]  pw;
        logic [3:0]  crs1;      // Also the move-out source
        logic [3:0]  crs2;
        logic [3:0]  crd;
        logic [4:0]  rd;
        logic [31:0] gpr_data;
        logic        exc;
    } cop_op_t;

    typedef struct packed {
        logic        exc;
        logic        gpr_wen;
        logic [4:0]  rd;
        logic [31:0] data;
    } cop_rsp_t;

endpackage

// ==== execute/scarv_cop_execute.sv ====
/*
 * Execute stage
 * Pops operations in order, updates the XCR file and holds the
 * response until the host takes it
 */
`timescale 1ns/1ps
`include "scarv_cop_config.svh"

module scarv_cop_execute (
    input  logic                   g_clk_i,
    input  logic                   arst_n_i,
    input  logic                   head_valid_i,
    input  scarv_cop_pkg::cop_op_t head_i,
    output logic                   pop_o,
    output logic                   rsp_valid_o,
    output scarv_cop_pkg::cop_rsp_t rsp_o,
    input  logic                   rsp_ready_i
);

    localparam int NXCR = `SCARV_COP_NXCR;

    logic [31:0] xcr_q [NXCR];

    logic [31:0]             palu_y;
    logic [31:0]             wdata;
    logic                    xcr_we;
    scarv_cop_pkg::cop_rsp_t rsp_d;

    scarv_cop_palu u_palu (
        .a_i   (xcr_q[head_i.crs1]),
        .b_i   (xcr_q[head_i.crs2]),
        .sub_i (head_i.sub),
        .pw_i  (head_i.pw),
        .y_o   (palu_y)
    );

    // Pop when the response slot is free or being drained
    assign pop_o = head_valid_i && (!rsp_valid_o || rsp_ready_i);

    assign xcr_we = pop_o && !head_i.exc && (head_i.cls != scarv_cop_pkg::MOVE_OUT);
    assign wdata  = (head_i.cls == scarv_cop_pkg::PACKED) ? palu_y : head_i.gpr_data;

    always_comb begin
        rsp_d         = '0;
        rsp_d.exc     = head_i.exc;
        rsp_d.rd      = head_i.rd;
        if (!head_i.exc) begin
            if (head_i.cls == scarv_cop_pkg::MOVE_OUT) begin
                rsp_d.gpr_wen = 1'b1;
                rsp_d.data    = xcr_q[head_i.crs1];
            end else begin
                rsp_d.data = wdata;  // Echo the written value
            end
        end
    end

    always_ff @(posedge g_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NXCR; i++) begin
                xcr_q[i] <= '0;
            end
        end else if (xcr_we) begin
            xcr_q[head_i.crd] <= wdata;
        end
    end

    always_ff @(posedge g_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else if (pop_o) begin
            rsp_valid_o <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
        end
    end

    // Held stable while the host stalls
    always_ff @(posedge g_clk_i) begin
        if (pop_o) begin
            rsp_o <= rsp_d;
        end
    end

endmodule

// ==== execute/scarv_cop_palu.sv ====
/*
 * Packed adder and subtractor
 * One ripple chain with carries cut at every lane start
 */
`timescale 1ns/1ps

module scarv_cop_palu (
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    input  logic        sub_i,
    input  logic [2:0]  pw_i,  // 0 gives 32-bit lanes, 4 gives 2-bit lanes
    output logic [31:0] y_o
);

    logic [31:0] lane_start;
    logic [31:0] b_x;

    // First bit of every lane
    always_comb begin
        case (pw_i)
            3'd1:    lane_start = 32'h0001_0001;
            3'd2:    lane_start = 32'h0101_0101;
            3'd3:    lane_start = 32'h1111_1111;
            3'd4:    lane_start = 32'h5555_5555;
            default: lane_start = 32'h0000_0001;
        endcase
    end

    assign b_x = sub_i ? ~b_i : b_i;  // Inverted operand plus one per lane

    always_comb begin
        logic c;
        c   = 1'b0;
        y_o = '0;
        for (int i = 0; i < 32; i++) begin
            if (lane_start[i]) begin
                c = sub_i;  // Fresh carry in for each lane
            end
            y_o[i] = a_i[i] ^ b_x[i] ^ c;
            c      = (a_i[i] & b_x[i]) | (c & (a_i[i] | b_x[i]));
        end
    end

endmodule

// ==== idecode/scarv_cop_idecode.sv ====
/*
 * Instruction decoder
 * Combinational map from a 32-bit encoding to a decoded operation,
 * raising an illegal instruction exception on bad encodings
 */
`timescale 1ns/1ps
`include "scarv_cop_config.svh"

module scarv_cop_idecode (
    input  scarv_cop_pkg::cop_insn_u insn_i,
    input  logic [31:0]              gpr_data_i,  // GPR source operand value
    output scarv_cop_pkg::cop_op_t   op_o
);

    logic                      opcode_ok;
    logic                      funct_bad;
    logic                      pw_bad;
    logic                      sub;
    scarv_cop_pkg::cop_class_e cls;

    assign opcode_ok = (insn_i.pk.opcode == `SCARV_COP_OPCODE);

    // Function code to class and operation
    always_comb begin
        cls       = scarv_cop_pkg::PACKED;
        sub       = 1'b0;
        funct_bad = 1'b0;
        case (insn_i.pk.funct)
            `SCARV_COP_F_PADD: begin
                cls = scarv_cop_pkg::PACKED;
            end
            `SCARV_COP_F_PSUB: begin
                cls = scarv_cop_pkg::PACKED;
                sub = 1'b1;
            end
            `SCARV_COP_F_GPR2XCR: begin
                cls = scarv_cop_pkg::MOVE_IN;
            end
            `SCARV_COP_F_XCR2GPR: begin
                cls = scarv_cop_pkg::MOVE_OUT;
            end
            default: begin
                funct_bad = 1'b1;  // Unknown function
            end
        endcase
    end

    // Only widths 32 down to 2 exist
    assign pw_bad = (cls == scarv_cop_pkg::PACKED) && (insn_i.pk.pw > 3'd4);

    always_comb begin
        op_o          = '0;
        op_o.cls      = cls;
        op_o.sub      = sub;
        op_o.gpr_data = gpr_data_i;
        op_o.exc      = !opcode_ok || funct_bad || pw_bad;

        case (cls)
            scarv_cop_pkg::PACKED: begin
                op_o.pw   = insn_i.pk.pw;
                op_o.crs1 = insn_i.pk.crs1;
                op_o.crs2 = insn_i.pk.crs2;
                op_o.crd  = insn_i.pk.crd;
            end
            scarv_cop_pkg::MOVE_IN: begin
                op_o.crd = insn_i.mv.crd;  // Data comes with the request
            end
            default: begin
                // Move out reads crs and targets a GPR
                op_o.crs1 = insn_i.mv.crs;
                op_o.rd   = {insn_i.mv.rd_hi, insn_i.mv.crd};
            end
        endcase
    end

endmodule

// ==== idecode/scarv_cop_issue.sv ====
/*
 * Issue stage
 * Accepts host requests against buffer credits, decodes them and
 * pushes the registered operation one cycle later
 */
`timescale 1ns/1ps
`include "scarv_cop_config.svh"

module scarv_cop_issue (
    input  logic                    g_clk_i,
    input  logic                    arst_n_i,
    input  logic                    req_valid_i,
    input  scarv_cop_pkg::cop_req_t req_i,
    output logic                    req_ready_o,
    input  logic                    credit_i,
    output logic                    push_o,
    output scarv_cop_pkg::cop_op_t  op_o
);

    localparam int DEPTH = `SCARV_COP_FIFO_DEPTH;
    localparam int CW    = $clog2(DEPTH) + 1;

    logic [CW-1:0]          credit_q;
    logic                   accept;
    scarv_cop_pkg::cop_op_t dec_op;

    scarv_cop_idecode u_idecode (
        .insn_i     (req_i.insn),
        .gpr_data_i (req_i.rs1_data),
        .op_o       (dec_op)
    );

    assign req_ready_o = (credit_q != '0);
    assign accept      = req_valid_i && req_ready_o;

    // Taken at acceptance, so the push one cycle later always has a slot
    always_ff @(posedge g_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_q <= CW'(DEPTH);
        end else if (accept && !credit_i) begin
            credit_q <= credit_q - 1'b1;
        end else if (!accept && credit_i) begin
            credit_q <= credit_q + 1'b1;
        end
    end

    always_ff @(posedge g_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            push_o <= 1'b0;
        end else begin
            push_o <= accept;  // One cycle pulse
        end
    end

    always_ff @(posedge g_clk_i) begin
        if (accept) begin
            op_o <= dec_op;
        end
    end

endmodule

// ==== scarv_cop.f ====
+incdir+common
common/scarv_cop_pkg.sv
idecode/scarv_cop_idecode.sv
idecode/scarv_cop_issue.sv
source/scarv_cop_op_fifo.sv
execute/scarv_cop_palu.sv
execute/scarv_cop_execute.sv
source/scarv_cop_top.sv
testbench/scarv_cop_tb_checks.sv
testbench/scarv_cop_tb.sv

// ==== source/scarv_cop_op_fifo.sv ====
/*
 * Operation buffer
 * In-order circular buffer of decoded operations, one credit per pop
 */
`timescale 1ns/1ps
`include "scarv_cop_config.svh"

module scarv_cop_op_fifo (
    input  logic                   g_clk_i,
    input  logic                   arst_n_i,
    input  logic                   push_i,
    input  scarv_cop_pkg::cop_op_t op_i,
    input  logic                   pop_i,
    output logic                   head_valid_o,
    output scarv_cop_pkg::cop_op_t head_o,
    output logic                   credit_o
);

    localparam int DEPTH = `SCARV_COP_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    scarv_cop_pkg::cop_op_t mem [DEPTH];

    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;
    logic          pop;

    assign head_valid_o = (count_q != '0);
    assign head_o       = mem[rd_ptr_q];
    assign pop          = pop_i && head_valid_o;

    // Occupancy is bounded by the issue credits
    always_ff @(posedge g_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)    rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push_i && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (!push_i && pop) begin
                count_q <= count_q - 1'b1;
            end
            credit_o <= pop;  // Slot freed
        end
    end

    always_ff @(posedge g_clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= op_i;
        end
    end

endmodule

// ==== source/scarv_cop_top.sv ====
/*
 * Packed arithmetic coprocessor top level
 * Issue stage, operation buffer and execute stage in a chain
 */
`timescale 1ns/1ps

module scarv_cop_top (
    input  logic                    g_clk_i,
    input  logic                    arst_n_i,
    input  logic                    req_valid_i,
    input  scarv_cop_pkg::cop_req_t req_i,
    output logic                    req_ready_o,
    output logic                    rsp_valid_o,
    output scarv_cop_pkg::cop_rsp_t rsp_o,
    input  logic                    rsp_ready_i
);

    logic                   push;
    logic                   credit;
    logic                   head_valid;
    logic                   pop;
    scarv_cop_pkg::cop_op_t op;
    scarv_cop_pkg::cop_op_t head;

    scarv_cop_issue u_issue (
        .g_clk_i     (g_clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .credit_i    (credit),
        .push_o      (push),
        .op_o        (op)
    );

    scarv_cop_op_fifo u_op_fifo (
        .g_clk_i      (g_clk_i),
        .arst_n_i     (arst_n_i),
        .push_i       (push),
        .op_i         (op),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_o       (head),
        .credit_o     (credit)
    );

    scarv_cop_execute u_execute (
        .g_clk_i      (g_clk_i),
        .arst_n_i     (arst_n_i),
        .head_valid_i (head_valid),
        .head_i       (head),
        .pop_o        (pop),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o),
        .rsp_ready_i  (rsp_ready_i)
    );

endmodule

// ==== testbench/scarv_cop_tb.sv ====
/*
 * Coprocessor testbench
 * Drives encoded instructions through the host port, predicts each
 * response with a register file and lane model, and reports the result
 */
`timescale 1ns/1ps
`include "scarv_cop_config.svh"

module scarv_cop_tb;

    localparam int DEPTH      = `SCARV_COP_FIFO_DEPTH;
    localparam int NXCR       = `SCARV_COP_NXCR;
    localparam int WAIT_LIMIT = 100;  // Cycles per wait

    logic                    g_clk_i;
    logic                    arst_n_i;
    logic                    req_valid_i;
    scarv_cop_pkg::cop_req_t req_i;
    logic                    req_ready_o;
    logic                    rsp_valid_o;
    scarv_cop_pkg::cop_rsp_t rsp_o;
    logic                    rsp_ready_i;

    logic [31:0] xcr_m [NXCR];      // Model register file
    logic [31:0] rng_state = 32'd7642;

    scarv_cop_top u_scarv_cop_top (
        .g_clk_i     (g_clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i)
    );

    scarv_cop_tb_checks u_checks (
        .g_clk_i     (g_clk_i),
        .arst_n_i    (arst_n_i),
        .rsp_valid_i (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_i       (rsp_o)
    );

    always #5 g_clk_i = ~g_clk_i;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_packed(input logic [3:0] funct, input logic [2:0] pw,
                                               input logic [3:0] crs1, input logic [3:0] crs2,
                                               input logic [3:0] crd);
        return {funct, pw, crs2, 2'b00, crs1, 4'b0000, crd, `SCARV_COP_OPCODE};
    endfunction

    function automatic logic [31:0] enc_move(input logic [3:0] funct, input logic [3:0] crs,
                                             input logic [4:0] rd);
        return {funct, 3'b000, crs, 1'b0, 5'd0, 3'b000, rd, `SCARV_COP_OPCODE};
    endfunction

    // Lane width is 32 >> pw and each lane wraps on its own
    function automatic logic [31:0] lane_addsub(input logic [31:0] a, input logic [31:0] b,
                                                input logic sub, input logic [2:0] pw);
        int          w;
        logic [63:0] mask;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] r;
        logic [31:0] y;
        w    = 32 >> pw;
        mask = (64'd1 << w) - 64'd1;
        y    = '0;
        for (int i = 0; i < 32 / w; i++) begin
            la = (64'(a) >> (i * w)) & mask;
            lb = (64'(b) >> (i * w)) & mask;
            r  = (sub ? la - lb : la + lb) & mask;
            y  = y | 32'(r << (i * w));
        end
        return y;
    endfunction

    task automatic predict(input logic [31:0] insn, input logic [31:0] gpr,
                           output scarv_cop_pkg::cop_rsp_t rsp, output logic we,
                           output logic [3:0] idx, output logic [31:0] val);
        logic [3:0] funct;
        logic [2:0] pw;
        logic       bad;
        funct = insn[31:28];
        pw    = insn[27:25];
        bad   = (insn[6:0] != `SCARV_COP_OPCODE) || (funct > `SCARV_COP_F_XCR2GPR) ||
                ((funct <= `SCARV_COP_F_PSUB) && (pw > 3'd4));
        rsp   = '0;
        we    = 1'b0;
        idx   = insn[10:7];
        val   = '0;
        if (bad) begin
            rsp.exc = 1'b1;  // No state change, data zero
        end else if (funct == `SCARV_COP_F_GPR2XCR) begin
            we       = 1'b1;
            val      = gpr;
            rsp.data = gpr;
        end else if (funct == `SCARV_COP_F_XCR2GPR) begin
            rsp.gpr_wen = 1'b1;
            rsp.rd      = insn[11:7];
            rsp.data    = xcr_m[insn[24:21]];
        end else begin
            val      = lane_addsub(xcr_m[insn[18:15]], xcr_m[insn[24:21]],
                                   funct == `SCARV_COP_F_PSUB, pw);
            we       = 1'b1;
            rsp.data = val;
        end
    endtask

    // Holds valid until ready or the wait limit
    // The model commits only on acceptance
    task automatic try_send(input logic [31:0] insn, input logic [31:0] gpr,
                            input int max_wait, output logic accepted);
        scarv_cop_pkg::cop_rsp_t rsp;
        logic                    we;
        logic [3:0]              idx;
        logic [31:0]             val;
        int                      waited;
        predict(insn, gpr, rsp, we, idx, val);
        @(negedge g_clk_i);
        req_valid_i = 1'b1;
        req_i       = {insn, gpr};
        waited      = 0;
        while (!req_ready_o && waited < max_wait) begin
            @(negedge g_clk_i);
            waited++;
        end
        if (req_ready_o) begin
            u_checks.expect_rsp(rsp);
            @(posedge g_clk_i);
            if (we) xcr_m[idx] = val;
            accepted = 1'b1;
        end else begin
            req_valid_i = 1'b0;
            accepted    = 1'b0;
        end
    endtask

    task automatic send(input logic [31:0] insn, input logic [31:0] gpr);
        logic ok;
        try_send(insn, gpr, WAIT_LIMIT, ok);
        if (!ok) u_checks.note_failure("request was not accepted before the timeout");
    endtask

    task automatic go_idle();
        @(negedge g_clk_i);
        req_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (u_checks.pending() != 0 && waited < WAIT_LIMIT) begin
            @(negedge g_clk_i);
            waited++;
        end
        if (u_checks.pending() != 0) begin
            u_checks.note_failure("expected responses did not arrive before the timeout");
        end
        repeat (4) @(negedge g_clk_i);  // Room for a stray extra response
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [31:0] w;
        logic [3:0]  r1;
        logic [3:0]  crd;
        logic [3:0]  funct;
        logic        ok;
        int          accepted;
        g_clk_i     = 1'b0;
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        rsp_ready_i = 1'b1;
        for (int i = 0; i < NXCR; i++) xcr_m[i] = '0;
        repeat (8) @(posedge g_clk_i);
        @(negedge g_clk_i);
        arst_n_i = 1'b1;

        u_checks.check_value("req_ready_o", 32'd1, 32'(req_ready_o));
        u_checks.check_value("rsp_valid_o", 32'd0, 32'(rsp_valid_o));
        for (int i = 0; i < NXCR; i++) begin
            send(enc_move(`SCARV_COP_F_XCR2GPR, 4'(i), 5'(i + 3)), next_rand());
        end
        go_idle();
        wait_drain();
        u_checks.finish_test("reset");

        for (int k = 0; k < 8; k++) begin
            r1 = 4'(next_rand());
            send(enc_move(`SCARV_COP_F_GPR2XCR, 4'd0, {1'b0, r1}), next_rand());
            send(enc_move(`SCARV_COP_F_XCR2GPR, r1, 5'(next_rand())), 32'd0);
        end
        go_idle();
        wait_drain();
        u_checks.finish_test("move");

        // Directed carry and borrow cases come before random operands
        for (int pw = 0; pw < 5; pw++) begin
            for (int n = 0; n < 5; n++) begin
                a     = (n == 0) ? 32'hFFFF_FFFF : (n == 1) ? 32'd0 : next_rand();
                b     = (n < 2) ? 32'd1 : next_rand();
                funct = (n == 0) ? `SCARV_COP_F_PADD :
                        (n == 1 || 1'(next_rand())) ? `SCARV_COP_F_PSUB : `SCARV_COP_F_PADD;
                r1    = 4'(next_rand());
                crd   = 4'(next_rand());
                send(enc_move(`SCARV_COP_F_GPR2XCR, 4'd0, {1'b0, r1}), a);
                send(enc_move(`SCARV_COP_F_GPR2XCR, 4'd0, {1'b0, r1 + 4'd1}), b);
                send(enc_packed(funct, 3'(pw), r1, r1 + 4'd1, crd), 32'd0);
                send(enc_move(`SCARV_COP_F_XCR2GPR, crd, 5'(next_rand())), 32'd0);
            end
        end
        go_idle();
        wait_drain();
        u_checks.finish_test("packed");

        crd = 4'd5;
        v   = next_rand();
        send(enc_move(`SCARV_COP_F_GPR2XCR, 4'd0, {1'b0, crd}), v);
        w   = enc_move(`SCARV_COP_F_GPR2XCR, 4'd0, {1'b0, crd});
        send({w[31:7], 7'h2B}, ~v);  // Wrong major opcode
        send(enc_packed(4'd4, 3'd0, 4'd1, 4'd2, crd), ~v);
        send(enc_packed(4'd9, 3'd1, 4'd1, 4'd2, crd), ~v);
        for (int pw = 5; pw < 8; pw++) begin
            send(enc_packed(`SCARV_COP_F_PADD, 3'(pw), 4'd1, 4'd2, crd), 32'd0);
        end
        send(enc_move(`SCARV_COP_F_XCR2GPR, crd, 5'd9), 32'd0);
        go_idle();
        wait_drain();
        u_checks.finish_test("illegal");

        @(negedge g_clk_i);
        rsp_ready_i = 1'b0;
        accepted    = 0;
        for (int k = 0; k < DEPTH + 4; k++) begin
            if (k % 2 == 0) begin
                w = enc_move(`SCARV_COP_F_GPR2XCR, 4'd0, {1'b0, 4'(next_rand())});
            end else begin
                w = enc_move(`SCARV_COP_F_XCR2GPR, 4'(next_rand()), 5'(next_rand()));
            end
            try_send(w, next_rand(), 8, ok);
            if (!ok) break;
            accepted++;
        end
        go_idle();
        u_checks.check_cond(accepted <= DEPTH + 2, "more requests accepted than can be held");
        u_checks.check_cond(accepted >= DEPTH, "req_ready_o fell before the buffer filled");
        u_checks.check_value("req_ready_o", 32'd0, 32'(req_ready_o));
        u_checks.check_value("rsp_valid_o", 32'd1, 32'(rsp_valid_o));
        @(negedge g_clk_i);
        rsp_ready_i = 1'b1;
        wait_drain();
        u_checks.finish_test("backpressure");

        u_checks.print_counts();
        if (u_checks.err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/scarv_cop_tb_checks.sv ====
/*
 * Coprocessor response checker
 * Compares every transferred response with the expected queue head
 * and keeps the per-test and total error counts
 */
`timescale 1ns/1ps

module scarv_cop_tb_checks (
    input logic                    g_clk_i,
    input logic                    arst_n_i,
    input logic                    rsp_valid_i,
    input logic                    rsp_ready_i,
    input scarv_cop_pkg::cop_rsp_t rsp_i
);

    scarv_cop_pkg::cop_rsp_t exp_q [$];  // Oldest outstanding first

    int err_count  = 0;
    int test_errs  = 0;
    int test_count = 0;
    int fail_count = 0;
    int rsp_count  = 0;

    task automatic expect_rsp(input scarv_cop_pkg::cop_rsp_t rsp);
        exp_q.push_back(rsp);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic note_failure(input string msg);
        $display("Check failed at %0t ns: %s", $time, msg);
        err_count++;
        test_errs++;
    endtask

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        assert (got === want) else begin
            $display("ERROR %0t ns %s expected %h got %h", $time, name, want, got);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_cond(input logic cond, input string msg);
        assert (cond) else note_failure(msg);
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (test_errs == 0) begin
            $display("test %-14s passed", name);
        end else begin
            fail_count++;
            $display("test %-14s failed with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic print_counts();
        $display("tests %0d, failed %0d, responses %0d, errors %0d",
                 test_count, fail_count, rsp_count, err_count);
    endtask

    // Transfer happens on the edge where valid and ready are both high
    always @(posedge g_clk_i) begin
        scarv_cop_pkg::cop_rsp_t want;
        if (arst_n_i && rsp_valid_i && rsp_ready_i) begin
            rsp_count++;
            if (exp_q.size() == 0) begin
                note_failure("response arrived with no request outstanding");
            end else begin
                want = exp_q.pop_front();
                check_value("rsp_o.exc", 32'(want.exc), 32'(rsp_i.exc));
                check_value("rsp_o.gpr_wen", 32'(want.gpr_wen), 32'(rsp_i.gpr_wen));
                check_value("rsp_o.data", want.data, rsp_i.data);
                if (want.gpr_wen) begin
                    check_value("rsp_o.rd", 32'(want.rd), 32'(rsp_i.rd));  // Only for GPR writes
                end
            end
        end
    end

endmodule
